//--- Bender.yml
package:
  name: execCore

sources:
  - hw/tomasuloPkg.sv
  - hw/issueIf.sv
  - hw/execIf.sv
  - hw/issueUnit.sv
  - hw/reservationStation.sv
  - hw/intAlu.sv
  - hw/resultBuffer.sv
  - hw/execCore.sv
  - target: test
    files:
      - tb/execCore_chk.sv
      - tb/execCoreTb.sv

//--- all.f
hw/tomasuloPkg.sv
hw/issueIf.sv
hw/execIf.sv
hw/issueUnit.sv
hw/reservationStation.sv
hw/intAlu.sv
hw/resultBuffer.sv
hw/execCore.sv
tb/execCore_chk.sv
tb/execCoreTb.sv

//--- hw/execCore.sv
`timescale 1ns/100ps
`default_nettype none

module execCore (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cyc,
    input  wire                       stb,
    input  wire                       we,
    input  wire tomasuloPkg::regIdx_t adr,
    input  wire tomasuloPkg::data_t   datIn,
    output tomasuloPkg::data_t        datOut,
    output logic                      ack,
    output logic                      cdbValid,
    output tomasuloPkg::tag_t         cdbTag,
    output tomasuloPkg::data_t        cdbData
);

    logic [tomasuloPkg::numSlots-1:0] slotFree;
    logic                             resValid;
    tomasuloPkg::tag_t                resTag;
    tomasuloPkg::data_t               resData;

    issueIf issueBus ();
    execIf  execBus ();

    // ====================
    // issue, station, ALU, then back around over the CDB

    issueUnit u_issueUnit (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datIn    (datIn),
        .datOut   (datOut),
        .ack      (ack),
        .slotFree (slotFree),
        .cdbValid (cdbValid),
        .cdbTag   (cdbTag),
        .cdbData  (cdbData),
        .issue    (issueBus.issuer)
    );

    reservationStation u_reservationStation (
        .clk      (clk),
        .rst      (rst),
        .issue    (issueBus.station),
        .exec     (execBus.station),
        .slotFree (slotFree),
        .cdbValid (cdbValid),
        .cdbTag   (cdbTag),
        .cdbData  (cdbData)
    );

    intAlu u_intAlu (
        .clk      (clk),
        .rst      (rst),
        .exec     (execBus.unit),
        .resValid (resValid),
        .resTag   (resTag),
        .resData  (resData)
    );

    resultBuffer u_resultBuffer (
        .clk      (clk),
        .rst      (rst),
        .resValid (resValid),
        .resTag   (resTag),
        .resData  (resData),
        .cdbValid (cdbValid),
        .cdbTag   (cdbTag),
        .cdbData  (cdbData)
    );

endmodule

`default_nettype wire

//--- hw/execIf.sv
`timescale 1ns/100ps
`default_nettype none

// one operation per cycle from the reservation station to the ALU
interface execIf;

    logic                  valid;
    tomasuloPkg::tag_t     tag;
    tomasuloPkg::opcode_t  op;
    tomasuloPkg::data_t    a;
    tomasuloPkg::data_t    b;

    modport station (output valid, tag, op, a, b);

    modport unit (input valid, tag, op, a, b);

endinterface

`default_nettype wire

//--- hw/intAlu.sv
`timescale 1ns/100ps
`default_nettype none

module intAlu (
    input  wire                clk,
    input  wire                rst,
    execIf.unit                exec,
    output logic               resValid,
    output tomasuloPkg::tag_t  resTag,
    output tomasuloPkg::data_t resData
);

    tomasuloPkg::data_t result;

    always_comb begin
        case (exec.op)
            tomasuloPkg::opAdd:   result = exec.a + exec.b;
            tomasuloPkg::opSub:   result = exec.a - exec.b;
            tomasuloPkg::opAnd:   result = exec.a & exec.b;
            tomasuloPkg::opOr:    result = exec.a | exec.b;
            tomasuloPkg::opXor:   result = exec.a ^ exec.b;
            tomasuloPkg::opSll:   result = exec.a << exec.b[4:0];
            tomasuloPkg::opLoadi: result = exec.a;   // imm already zero-extended by the station
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            resTag  <= exec.tag;
            resData <= result;
        end
    end

endmodule

`default_nettype wire

//--- hw/issueIf.sv
`timescale 1ns/100ps
`default_nettype none

// renamed instruction on its way into the reservation station
interface issueIf;

    logic                                valid;
    tomasuloPkg::opcode_t                op;
    tomasuloPkg::tag_t                   tag;    // slot that receives the entry
    tomasuloPkg::data_t                  val1;
    tomasuloPkg::tag_t                   q1;
    tomasuloPkg::data_t                  val2;
    tomasuloPkg::tag_t                   q2;
    logic [tomasuloPkg::immWidth-1:0]    imm;

    modport issuer (output valid, op, tag, val1, q1, val2, q2, imm);

    modport station (input valid, op, tag, val1, q1, val2, q2, imm);

endinterface

`default_nettype wire

//--- hw/issueUnit.sv
`timescale 1ns/100ps
`default_nettype none

module issueUnit (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             cyc,
    input  wire                             stb,
    input  wire                             we,
    input  wire tomasuloPkg::regIdx_t       adr,
    input  wire tomasuloPkg::data_t         datIn,
    output tomasuloPkg::data_t              datOut,
    output logic                            ack,
    input  wire [tomasuloPkg::numSlots-1:0] slotFree,
    input  wire                             cdbValid,
    input  wire tomasuloPkg::tag_t          cdbTag,
    input  wire tomasuloPkg::data_t         cdbData,
    issueIf.issuer                          issue
);

    tomasuloPkg::data_t regVal [tomasuloPkg::numRegs];
    tomasuloPkg::tag_t  regTag [tomasuloPkg::numRegs];   // pending writer per register

    tomasuloPkg::instr_t              instr;
    logic [tomasuloPkg::numSlots-1:0] freeLow;
    tomasuloPkg::tag_t                newTag;
    tomasuloPkg::data_t               val1;
    tomasuloPkg::data_t               val2;
    tomasuloPkg::tag_t                q1;
    tomasuloPkg::tag_t                q2;
    logic                             request;
    logic                             doIssue;
    logic                             doRead;

    assign instr   = datIn;
    assign request = cyc & stb & ~ack;   // no second ack while the master still sees this one
    assign doIssue = request & we & (|slotFree);
    assign doRead  = request & ~we & (regTag[adr] == tomasuloPkg::tagNone);
    assign freeLow = slotFree & (-slotFree);

    always_comb begin
        newTag = tomasuloPkg::tagNone;
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            if (freeLow[i]) begin
                newTag = tomasuloPkg::tag_t'(i + 1);
            end
        end
    end

    // ====================
    // operand renaming with CDB bypass

    always_comb begin
        val1 = regVal[instr.src1];
        q1   = regTag[instr.src1];
        val2 = regVal[instr.src2];
        q2   = regTag[instr.src2];
        if (cdbValid && q1 == cdbTag) begin
            val1 = cdbData;
            q1   = tomasuloPkg::tagNone;
        end
        if (cdbValid && q2 == cdbTag) begin
            val2 = cdbData;
            q2   = tomasuloPkg::tagNone;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack         <= 1'b0;
            issue.valid <= 1'b0;
            for (int r = 0; r < tomasuloPkg::numRegs; r++) begin
                regVal[r] <= '0;
                regTag[r] <= tomasuloPkg::tagNone;
            end
        end else begin
            ack         <= doIssue | doRead;
            issue.valid <= doIssue;
            for (int r = 0; r < tomasuloPkg::numRegs; r++) begin
                if (cdbValid && regTag[r] == cdbTag) begin
                    regVal[r] <= cdbData;
                    regTag[r] <= tomasuloPkg::tagNone;
                end
            end
            if (doIssue) begin
                regTag[instr.dst] <= newTag;   // a retag in the same cycle wins over the CDB
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doIssue) begin
            issue.op   <= instr.op;
            issue.tag  <= newTag;
            issue.val1 <= val1;
            issue.q1   <= q1;
            issue.val2 <= val2;
            issue.q2   <= q2;
            issue.imm  <= instr.imm;
        end
        if (doRead) begin
            datOut <= regVal[adr];
        end
    end

endmodule

`default_nettype wire

//--- hw/reservationStation.sv
`timescale 1ns/100ps
`default_nettype none

module reservationStation (
    input  wire                             clk,
    input  wire                             rst,
    issueIf.station                         issue,
    execIf.station                          exec,
    output logic [tomasuloPkg::numSlots-1:0] slotFree,
    input  wire                             cdbValid,
    input  wire tomasuloPkg::tag_t          cdbTag,
    input  wire tomasuloPkg::data_t         cdbData
);

    tomasuloPkg::opcode_t             slotOp  [tomasuloPkg::numSlots];
    logic [tomasuloPkg::immWidth-1:0] slotImm [tomasuloPkg::numSlots];
    tomasuloPkg::data_t               val1    [tomasuloPkg::numSlots];
    tomasuloPkg::data_t               val2    [tomasuloPkg::numSlots];
    tomasuloPkg::tag_t                q1      [tomasuloPkg::numSlots];
    tomasuloPkg::tag_t                q2      [tomasuloPkg::numSlots];

    logic [tomasuloPkg::numSlots-1:0] busy;
    logic [tomasuloPkg::numSlots-1:0] dispatched;
    logic [tomasuloPkg::numSlots-1:0] ready;
    logic [tomasuloPkg::numSlots-1:0] pick;

    assign slotFree = ~busy;
    assign pick     = ready & (-ready);   // lowest ready slot only

    always_comb begin
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            ready[i] = busy[i] & ~dispatched[i] &
                       (q1[i] == tomasuloPkg::tagNone) & (q2[i] == tomasuloPkg::tagNone);
        end
    end

    // ====================
    // dispatch

    always_comb begin
        exec.valid = |pick;
        exec.tag   = tomasuloPkg::tagNone;
        exec.op    = tomasuloPkg::opAdd;
        exec.a     = '0;
        exec.b     = '0;
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            if (pick[i]) begin
                exec.tag = tomasuloPkg::tag_t'(i + 1);
                exec.op  = slotOp[i];
                exec.a   = (slotOp[i] == tomasuloPkg::opLoadi) ?
                           tomasuloPkg::data_t'(slotImm[i]) : val1[i];
                exec.b   = val2[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= '0;
            dispatched <= '0;
        end else begin
            for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
                if (issue.valid && issue.tag == tomasuloPkg::tag_t'(i + 1)) begin
                    busy[i]       <= 1'b1;
                    dispatched[i] <= 1'b0;
                end else if (cdbValid && cdbTag == tomasuloPkg::tag_t'(i + 1)) begin
                    busy[i]       <= 1'b0;   // slot lives until its own result is out
                    dispatched[i] <= 1'b0;
                end else if (pick[i]) begin
                    dispatched[i] <= 1'b1;
                end
            end
        end
    end

    // ====================
    // operand capture

    always_ff @(posedge clk) begin
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            if (issue.valid && issue.tag == tomasuloPkg::tag_t'(i + 1)) begin
                slotOp[i]  <= issue.op;
                slotImm[i] <= issue.imm;
                val1[i]    <= (cdbValid && issue.q1 == cdbTag) ? cdbData : issue.val1;
                q1[i]      <= (cdbValid && issue.q1 == cdbTag) ? tomasuloPkg::tagNone : issue.q1;
                val2[i]    <= (cdbValid && issue.q2 == cdbTag) ? cdbData : issue.val2;
                q2[i]      <= (cdbValid && issue.q2 == cdbTag) ? tomasuloPkg::tagNone : issue.q2;
            end else if (busy[i] && cdbValid) begin
                if (q1[i] == cdbTag) begin
                    val1[i] <= cdbData;
                    q1[i]   <= tomasuloPkg::tagNone;
                end
                if (q2[i] == cdbTag) begin
                    val2[i] <= cdbData;
                    q2[i]   <= tomasuloPkg::tagNone;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/resultBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module resultBuffer (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      resValid,
    input  wire tomasuloPkg::tag_t   resTag,
    input  wire tomasuloPkg::data_t  resData,
    output logic                     cdbValid,
    output tomasuloPkg::tag_t        cdbTag,
    output tomasuloPkg::data_t       cdbData
);

    tomasuloPkg::data_t               bufData [tomasuloPkg::numSlots];
    logic [tomasuloPkg::numSlots-1:0] occupied;
    logic [tomasuloPkg::numSlots-1:0] pick;
    logic [tomasuloPkg::numSlots-1:0] incoming;

    // broadcast order is slot order and has nothing to do with program order
    assign pick = occupied & (-occupied);

    always_comb begin
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            incoming[i] = resValid && (resTag == tomasuloPkg::tag_t'(i + 1));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= '0;
            cdbValid <= 1'b0;
            cdbTag   <= tomasuloPkg::tagNone;
        end else begin
            occupied <= (occupied & ~pick) | incoming;
            cdbValid <= |occupied;
            cdbTag   <= tomasuloPkg::tagNone;
            for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
                if (pick[i]) begin
                    cdbTag <= tomasuloPkg::tag_t'(i + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            if (incoming[i]) begin
                bufData[i] <= resData;
            end
            if (pick[i]) begin
                cdbData <= bufData[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tomasuloPkg.sv
`default_nettype none

package tomasuloPkg;

    // ====================
    // widths and sizes

    localparam int dataWidth   = 32;
    localparam int numRegs     = 8;
    localparam int regIdxWidth = 3;
    localparam int numSlots    = 4;
    localparam int tagWidth    = 3;   // slot i carries tag i+1
    localparam int immWidth    = 16;

    typedef logic [dataWidth-1:0]   data_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;
    typedef logic [tagWidth-1:0]    tag_t;

    // a register or operand with this tag already holds its value
    localparam tag_t tagNone = '0;

    // ====================
    // instruction format

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opLoadi
    } opcode_t;

    typedef struct packed {
        opcode_t               op;
        regIdx_t               dst;
        regIdx_t               src1;
        regIdx_t               src2;
        logic [3:0]            spare;
        logic [immWidth-1:0]   imm;
    } instr_t;

endpackage

`default_nettype wire

//--- tb/execCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module execCoreTb;

    localparam int drvDelay   = 10;
    localparam int numLoadi   = 24;
    localparam int numRandom  = 200;
    localparam int numBursts  = 4;
    localparam int burstLen   = 8;
    localparam int numPairs   = 20;
    localparam int numTxn     = 8 + (numLoadi + 8) + (numRandom + 8) +
                                (numBursts * burstLen + 8) + 2 * numPairs;
    localparam int cycleLimit = 40 * numTxn;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    tomasuloPkg::regIdx_t adr;
    tomasuloPkg::data_t   datIn;
    tomasuloPkg::data_t   datOut;
    logic                 ack;
    logic                 cdbValid;
    tomasuloPkg::tag_t    cdbTag;
    tomasuloPkg::data_t   cdbData;

    integer seed;
    int     dataErrors;
    int     tagErrors;
    int     cycleCount;

    tomasuloPkg::data_t               model [tomasuloPkg::numRegs];   // registers in program order
    tomasuloPkg::data_t               nextResult;   // result of the write being acknowledged
    tomasuloPkg::data_t               expectData [tomasuloPkg::numSlots];
    logic [tomasuloPkg::numSlots-1:0] slotBusy;
    logic [tomasuloPkg::numSlots-1:0] clearNext;   // slot frees one cycle after its broadcast
    int                               issued    [tomasuloPkg::numSlots];
    int                               broadcast [tomasuloPkg::numSlots];

    execCore u_execCore (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datIn    (datIn),
        .datOut   (datOut),
        .ack      (ack),
        .cdbValid (cdbValid),
        .cdbTag   (cdbTag),
        .cdbData  (cdbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // reference model and checks

    function automatic tomasuloPkg::data_t refResult(input tomasuloPkg::instr_t ins);
        tomasuloPkg::data_t a;
        tomasuloPkg::data_t b;
        a = model[ins.src1];
        b = model[ins.src2];
        case (ins.op)
            tomasuloPkg::opAdd:   return a + b;
            tomasuloPkg::opSub:   return a - b;
            tomasuloPkg::opAnd:   return a & b;
            tomasuloPkg::opOr:    return a | b;
            tomasuloPkg::opXor:   return a ^ b;
            tomasuloPkg::opSll:   return a << b[4:0];
            tomasuloPkg::opLoadi: return {16'h0000, ins.imm};
            default:              return '0;
        endcase
    endfunction

    task automatic checkReg(input tomasuloPkg::regIdx_t idx, input tomasuloPkg::data_t expected,
                            input tomasuloPkg::data_t actual);
        if (actual !== expected) begin
            dataErrors++;
            $display("FAILED at %0t: datOut for r%0d expected %h, actual %h",
                     $time, idx, expected, actual);
        end
    endtask

    task automatic checkCdbData(input tomasuloPkg::tag_t tag, input tomasuloPkg::data_t expected,
                                input tomasuloPkg::data_t actual);
        if (actual !== expected) begin
            dataErrors++;
            $display("FAILED at %0t: cdbData for tag %0d expected %h, actual %h",
                     $time, tag, expected, actual);
        end
    endtask

    task automatic checkCdbTag(input tomasuloPkg::tag_t tag);
        if (tag < 1 || tag > tomasuloPkg::numSlots) begin
            tagErrors++;
            $display("cdbTag %0d at %0t does not name any reservation slot", tag, $time);
        end else if (!slotBusy[tag-1]) begin
            tagErrors++;
            $display("cdbTag %0d broadcast at %0t with no outstanding issue", tag, $time);
        end else begin
            checkCdbData(tag, expectData[tag-1], cdbData);
            broadcast[tag-1]++;
            clearNext[tag-1] = 1'b1;
        end
    endtask

    task automatic allocateTag();
        int pick;
        pick = -1;
        for (int i = tomasuloPkg::numSlots - 1; i >= 0; i--) begin
            if (!slotBusy[i]) pick = i;   // lowest free slot wins
        end
        if (pick < 0) begin
            tagErrors++;
            $display("write acknowledged at %0t while every slot was busy", $time);
        end else begin
            slotBusy[pick]   = 1'b1;
            expectData[pick] = nextResult;
            issued[pick]++;
        end
    endtask

    // the DUT decides on the edge before the ack cycle, before any free from that edge
    always @(negedge clk) begin
        if (!rst) begin
            if (ack && we) begin
                allocateTag();
            end
            slotBusy  = slotBusy & ~clearNext;
            clearNext = '0;
            if (cdbValid) begin
                checkCdbTag(cdbTag);
            end
        end
    end

    // ====================
    // Wishbone master

    task automatic waitAck();
        @(posedge clk);
        #drvDelay;
        while (!ack) begin
            @(posedge clk);
            #drvDelay;
        end
    endtask

    task automatic releaseBus();
        cyc = 1'b0;
        stb = 1'b0;
        @(posedge clk);
        #drvDelay;
    endtask

    task automatic wbWrite(input tomasuloPkg::instr_t ins);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        datIn = ins;
        waitAck();
        model[ins.dst] = refResult(ins);
        nextResult     = model[ins.dst];
        releaseBus();
    endtask

    task automatic wbRead(input tomasuloPkg::regIdx_t idx);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = idx;
        waitAck();
        checkReg(idx, model[idx], datOut);
        releaseBus();
    endtask

    task automatic readAll();
        for (int r = 0; r < tomasuloPkg::numRegs; r++) begin
            wbRead(tomasuloPkg::regIdx_t'(r));
        end
    endtask

    // opLoadi is the last opcode, so numOps of 6 leaves it out
    task automatic randomInstr(input int numOps, output tomasuloPkg::instr_t ins);
        logic [31:0] r;
        r        = $random(seed);
        ins.op   = tomasuloPkg::opcode_t'(r % numOps);
        r        = $random(seed);
        ins.dst  = r[2:0];
        ins.src1 = r[6:4];
        ins.src2 = r[10:8];
        ins.spare = '0;
        r        = $random(seed);
        ins.imm  = r[15:0];
    endtask

    initial begin
        tomasuloPkg::instr_t  ins;
        tomasuloPkg::regIdx_t prevDst;
        seed       = 32'h28e1_26bd;
        dataErrors = 0;
        tagErrors  = 0;
        rst        = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        datIn      = '0;
        slotBusy   = '0;
        clearNext  = '0;
        for (int r = 0; r < tomasuloPkg::numRegs; r++) model[r] = '0;
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            issued[i]    = 0;
            broadcast[i] = 0;
        end
        repeat (3) @(posedge clk);
        #drvDelay rst = 1'b0;

        readAll();   // registers come out of reset as zero

        repeat (numLoadi) begin
            randomInstr(7, ins);
            ins.op = tomasuloPkg::opLoadi;
            wbWrite(ins);
        end
        readAll();

        repeat (numRandom) begin
            randomInstr(7, ins);
            wbWrite(ins);
        end
        readAll();

        // chains longer than the station so ack has to stall
        repeat (numBursts) begin
            prevDst = tomasuloPkg::regIdx_t'($random(seed));
            repeat (burstLen) begin
                randomInstr(6, ins);
                ins.src1 = prevDst;
                wbWrite(ins);
                prevDst = ins.dst;
            end
        end
        readAll();

        repeat (numPairs) begin
            randomInstr(7, ins);
            wbWrite(ins);
            wbRead(ins.dst);
        end

        while (slotBusy != '0) @(posedge clk);
        for (int i = 0; i < tomasuloPkg::numSlots; i++) begin
            if (issued[i] != broadcast[i]) begin
                tagErrors++;
                $display("FAILED at %0t: broadcasts of cdbTag %0d expected %0d, actual %0d",
                         $time, i + 1, issued[i], broadcast[i]);
            end
        end

        $display("errors: %0d data, %0d cdb tag", dataErrors, tagErrors);
        if (dataErrors == 0 && tagErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("errors: %0d data, %0d cdb tag", dataErrors, tagErrors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/execCore_chk.sv
`timescale 1ns/100ps
`default_nettype none

module execCoreChk (
    input wire                    clk,
    input wire                    rst,
    input wire                    cyc,
    input wire                    stb,
    input wire                    ack,
    input wire                    cdbValid,
    input wire tomasuloPkg::tag_t cdbTag
);

    // ====================
    // Wishbone slave

    ackFollowsRequest: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb))
        else $error("ack without a request in the cycle before");

    ackSinglePulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // ====================
    // CDB

    cdbTagPresent: assert property (@(posedge clk) disable iff (rst)
        cdbValid |-> cdbTag != tomasuloPkg::tagNone)
        else $error("CDB broadcast carries the empty tag");

    quietInReset: assert property (@(posedge clk) rst |-> !ack && !cdbValid)
        else $error("ack or cdbValid high during reset");   // both are cleared asynchronously

endmodule

bind execCore execCoreChk u_execCoreChk (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .ack      (ack),
    .cdbValid (cdbValid),
    .cdbTag   (cdbTag)
);

`default_nettype wire
